// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := controlUnitTb
FILELIST := src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== src.f ====
verilog/mipsIsaPkg.sv
verilog/controlPkg.sv
verilog/instrClassifier.sv
verilog/controlSequencer.sv
verilog/datapathControlDecode.sv
verilog/mipsControlUnit.sv
test/controlUnitTb.sv

// ==== test/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb
    import mipsIsaPkg::*, controlPkg::*;
();

    localparam int numInstr  = 300;
    localparam int irTimeout = 16; // longest gap is 9 cycles

    // kinds 0..8 map straight onto these and kinds 9..10 are undefined encodings
    localparam logic [fieldWidth-1:0] opList [9] = '{opSpecial, opAddi, opAddiu, opLw, opSw,
                                                     opBeq, opBne, opJ, opJal};
    localparam logic [classWidth-1:0] clsList [9] = '{clsAdd, clsAddi, clsAddiu, clsLoad,
                                                      clsStore, clsBeq, clsBne, clsJump, clsJal};

    logic clk;
    logic rst;
    logic [fieldWidth-1:0] opcode;
    logic [fieldWidth-1:0] funct;
    logic overflow;
    logic pcWrite, pcWriteCond, branchOnNotEqual, memWrite, irWrite, regWrite;
    logic operandLoad, aluSrcA, aluOutWrite, epcWrite, mdrLoad;
    logic [addrSrcWidth-1:0] addrSrc;
    logic [srcBWidth-1:0]    aluSrcB;
    logic [aluOpWidth-1:0]   aluOp;
    logic [pcSrcWidth-1:0]   pcSrc;
    logic [dstWidth-1:0]     regDst;
    logic [dataSrcWidth-1:0] regDataSrc;

    int seed = 32'hfb42;

    logic [classWidth-1:0] curCls;  // instruction presented after the last irWrite
    logic curOvf;
    logic started;
    logic [7:0] cyc;                // 1 in the decode cycle
    logic [7:0] regWrites;

    logic trapExp;
    logic excPath;
    logic aluWrite;
    logic [7:0] excStart;
    logic [7:0] expGap;
    logic [7:0] expRegWrites;
    logic [addrSrcWidth-1:0] excVec;

    mipsControlUnit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // execute cycles per class, from the latency table
    function automatic logic [7:0] execCycles(input logic [classWidth-1:0] cls, input logic trap);
        if (trap) begin
            return 8'd5;
        end
        case (cls)
            clsAdd, clsAddi, clsAddiu, clsStore, clsJal: return 8'd2;
            clsLoad:                                      return 8'd5;
            clsBeq, clsBne, clsJump:                      return 8'd1;
            default:                                      return 8'd4; // invalid opcode
        endcase
    endfunction

    assign trapExp  = curOvf && (curCls == clsAdd || curCls == clsAddi);
    assign excPath  = trapExp || curCls == clsInvalid;
    assign excStart = trapExp ? 8'd3 : 8'd2;
    assign excVec   = trapExp ? addrVecOverflow : addrVecInvalid;
    assign expGap   = execCycles(curCls, trapExp) + 8'd4;
    assign aluWrite = (curCls == clsAdd || curCls == clsAddi || curCls == clsAddiu) && !trapExp;
    assign expRegWrites = (aluWrite || curCls == clsLoad || curCls == clsJal) ? 8'd1 : 8'd0;

    always @(posedge clk) begin
        if (rst || irWrite) begin
            cyc       <= 8'd1;
            regWrites <= 8'd0;
        end else begin
            cyc       <= cyc + 8'd1;
            regWrites <= regWrites + 8'(regWrite);
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
        $display("STATUS: FAIL");
        $fatal(1, "%s mismatch", name);
    endtask

    spInit: assert property (@(posedge clk) $fell(rst) |->
        {regWrite, regDst, regDataSrc} == {1'b1, dstSp, dataSpInit})
        else reportMismatch("regWrite,regDst,regDataSrc",
            32'($sampled({regWrite, regDst, regDataSrc})), 32'({1'b1, dstSp, dataSpInit}));
    // pc + 4 on the first fetch
    firstFetch: assert property (@(posedge clk) $fell(rst) |=>
        {pcWrite, pcSrc, aluSrcA, aluSrcB, aluOp} == {1'b1, pcFromAlu, 1'b0, srcBFour, aluAdd})
        else reportMismatch("pcWrite,pcSrc,aluSrcA,aluSrcB,aluOp",
            32'($sampled({pcWrite, pcSrc, aluSrcA, aluSrcB, aluOp})),
            32'({1'b1, pcFromAlu, 1'b0, srcBFour, aluAdd}));
    // operands latched and branch target computed from pc
    decodeCycle: assert property (@(posedge clk) disable iff (rst) started && cyc == 1
        |-> {operandLoad, aluOutWrite, aluSrcA, aluSrcB, aluOp}
            == {1'b1, 1'b1, 1'b0, srcBBranchOff, aluAdd})
        else reportMismatch("operandLoad,aluOutWrite,aluSrcA,aluSrcB,aluOp",
            32'($sampled({operandLoad, aluOutWrite, aluSrcA, aluSrcB, aluOp})),
            32'({1'b1, 1'b1, 1'b0, srcBBranchOff, aluAdd}));
    latency: assert property (@(posedge clk) disable iff (rst) started && irWrite |-> cyc == expGap)
        else reportMismatch("irWrite interval", 32'($sampled(cyc)), 32'($sampled(expGap)));
    regWriteCount: assert property (@(posedge clk) disable iff (rst)
        started && irWrite |-> regWrites == expRegWrites)
        else reportMismatch("regWrite count", 32'($sampled(regWrites)),
            32'($sampled(expRegWrites)));
    aluWriteBack: assert property (@(posedge clk) disable iff (rst) started && aluWrite && cyc == 3
        |-> {regWrite, regDst, regDataSrc} == {1'b1, curCls == clsAdd ? dstRd : dstRt, dataAluOut})
        else reportMismatch("regWrite,regDst,regDataSrc",
            32'($sampled({regWrite, regDst, regDataSrc})), 32'($sampled({1'b1,
            curCls == clsAdd ? dstRd : dstRt, dataAluOut})));
    // memory written only by stores in the cycle after the address
    storeOnly: assert property (@(posedge clk) disable iff (rst)
        started && memWrite |-> curCls == clsStore && cyc == 3)
        else reportMismatch("memWrite", 32'd1, 32'd0);
    storeAddr: assert property (@(posedge clk) disable iff (rst) started && curCls == clsStore &&
        cyc == 3 |-> {memWrite, addrSrc} == {1'b1, addrAluOut})
        else reportMismatch("memWrite,addrSrc", 32'($sampled({memWrite, addrSrc})),
            32'({1'b1, addrAluOut}));
    loadCapture: assert property (@(posedge clk) disable iff (rst)
        started && curCls == clsLoad && cyc == 5 |-> mdrLoad)
        else reportMismatch("mdrLoad", 32'($sampled(mdrLoad)), 32'd1);
    loadWrite: assert property (@(posedge clk) disable iff (rst) started && curCls == clsLoad &&
        cyc == 6 |-> {regWrite, regDataSrc} == {1'b1, dataMem})
        else reportMismatch("regWrite,regDataSrc", 32'($sampled({regWrite, regDataSrc})),
            32'({1'b1, dataMem}));
    branchOnce: assert property (@(posedge clk) disable iff (rst) started && pcWriteCond
        |-> (curCls == clsBeq || curCls == clsBne) && cyc == 2)
        else reportMismatch("pcWriteCond", 32'd1, 32'd0);
    branchSense: assert property (@(posedge clk) disable iff (rst) started && cyc == 2 &&
        (curCls == clsBeq || curCls == clsBne)
        |-> {pcWriteCond, branchOnNotEqual} == {1'b1, curCls == clsBne})
        else reportMismatch("pcWriteCond,branchOnNotEqual",
            32'($sampled({pcWriteCond, branchOnNotEqual})), 32'($sampled({1'b1, curCls == clsBne})));
    jalLink: assert property (@(posedge clk) disable iff (rst) started && curCls == clsJal &&
        cyc == 2 |-> {regWrite, regDst, regDataSrc} == {1'b1, dstRa, dataPc})
        else reportMismatch("regWrite,regDst,regDataSrc",
            32'($sampled({regWrite, regDst, regDataSrc})), 32'({1'b1, dstRa, dataPc}));
    jumpTarget: assert property (@(posedge clk) disable iff (rst) started &&
        (curCls == clsJump || curCls == clsJal) && cyc == (curCls == clsJal ? 8'd3 : 8'd2)
        |-> {pcWrite, pcSrc} == {1'b1, pcFromJump})
        else reportMismatch("pcWrite,pcSrc", 32'($sampled({pcWrite, pcSrc})),
            32'({1'b1, pcFromJump}));
    excSave: assert property (@(posedge clk) disable iff (rst) started && excPath &&
        cyc == excStart |-> {epcWrite, addrSrc} == {1'b1, excVec})
        else reportMismatch("epcWrite,addrSrc", 32'($sampled({epcWrite, addrSrc})),
            32'($sampled({1'b1, excVec})));
    excLoad: assert property (@(posedge clk) disable iff (rst)
        started && excPath && cyc == excStart + 8'd2 |-> mdrLoad)
        else reportMismatch("mdrLoad", 32'($sampled(mdrLoad)), 32'd1);
    excJump: assert property (@(posedge clk) disable iff (rst) started && excPath &&
        cyc == excStart + 8'd3 |-> {pcWrite, pcSrc} == {1'b1, pcFromException})
        else reportMismatch("pcWrite,pcSrc", 32'($sampled({pcWrite, pcSrc})),
            32'({1'b1, pcFromException}));

    task automatic waitForIrWrite();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irWrite) begin
            if (waited == irTimeout) begin
                $display("irWrite did not pulse within %0d cycles", irTimeout);
                $display("STATUS: FAIL");
                $fatal(1, "timeout waiting for instruction fetch");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic pickInstruction();
        int          kind;
        logic [31:0] rnd;
        kind = {$random(seed)} % 11;
        rnd  = $random(seed);
        funct    <= rnd[5:0];
        overflow <= rnd[6];   // also high for addiu and non-alu classes
        curOvf   <= rnd[6];
        started  <= 1'b1;
        if (kind < 9) begin
            opcode <= opList[kind];
            curCls <= clsList[kind];
        end else begin
            opcode <= (kind == 9) ? {2'b11, rnd[10:7]} : opSpecial; // 0x30..0x3f unused
            curCls <= clsInvalid;
        end
        if (kind == 0) begin
            funct <= functAdd;
        end else if (kind == 10) begin
            funct <= {1'b0, rnd[11:7]}; // never the add funct
        end
    endtask

    initial begin
        rst      = 1'b1;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        started  = 1'b0;
        curCls   = clsInvalid;
        curOvf   = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < numInstr; i++) begin
            waitForIrWrite();
            pickInstruction();
        end
        waitForIrWrite(); // closes the interval of the last instruction
        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/controlPkg.sv ====
`default_nettype none

package controlPkg;

    localparam int stateWidth   = 5;
    localparam int addrSrcWidth = 2;
    localparam int srcBWidth    = 2;
    localparam int aluOpWidth   = 3;
    localparam int pcSrcWidth   = 2;
    localparam int dstWidth     = 2;
    localparam int dataSrcWidth = 2;

    // shared prologue
    localparam logic [stateWidth-1:0] stStackInit   = 5'd0;
    localparam logic [stateWidth-1:0] stFetchAddr   = 5'd1;
    localparam logic [stateWidth-1:0] stFetchWait   = 5'd2;
    localparam logic [stateWidth-1:0] stFetchLoad   = 5'd3;
    localparam logic [stateWidth-1:0] stDecode      = 5'd4;
    // alu instructions
    localparam logic [stateWidth-1:0] stAluExec     = 5'd5;
    localparam logic [stateWidth-1:0] stAluWrite    = 5'd6;
    localparam logic [stateWidth-1:0] stAluWriteImm = 5'd7;
    // memory
    localparam logic [stateWidth-1:0] stMemAddr     = 5'd8;
    localparam logic [stateWidth-1:0] stLoadRead    = 5'd9;
    localparam logic [stateWidth-1:0] stLoadWait    = 5'd10;
    localparam logic [stateWidth-1:0] stLoadCapture = 5'd11;
    localparam logic [stateWidth-1:0] stLoadWrite   = 5'd12;
    localparam logic [stateWidth-1:0] stStoreWrite  = 5'd13;
    // control transfer
    localparam logic [stateWidth-1:0] stBranch      = 5'd14;
    localparam logic [stateWidth-1:0] stJalLink     = 5'd15;
    localparam logic [stateWidth-1:0] stJump        = 5'd16;
    // exception entry
    localparam logic [stateWidth-1:0] stExcSave     = 5'd17;
    localparam logic [stateWidth-1:0] stExcWait     = 5'd18;
    localparam logic [stateWidth-1:0] stExcLoad     = 5'd19;
    localparam logic [stateWidth-1:0] stExcJump     = 5'd20; // highest code in use

    // memory address mux
    localparam logic [addrSrcWidth-1:0] addrPc          = 2'd0;
    localparam logic [addrSrcWidth-1:0] addrAluOut      = 2'd1;
    localparam logic [addrSrcWidth-1:0] addrVecInvalid  = 2'd2;
    localparam logic [addrSrcWidth-1:0] addrVecOverflow = 2'd3;

    // alu operand b mux
    localparam logic [srcBWidth-1:0] srcBReg       = 2'd0;
    localparam logic [srcBWidth-1:0] srcBFour      = 2'd1;
    localparam logic [srcBWidth-1:0] srcBImm       = 2'd2;
    localparam logic [srcBWidth-1:0] srcBBranchOff = 2'd3; // sign extended, shifted by 2

    localparam logic [aluOpWidth-1:0] aluAdd = 3'b001;
    localparam logic [aluOpWidth-1:0] aluSub = 3'b010;

    // next pc mux
    localparam logic [pcSrcWidth-1:0] pcFromAlu       = 2'd0;
    localparam logic [pcSrcWidth-1:0] pcFromAluOut    = 2'd1;
    localparam logic [pcSrcWidth-1:0] pcFromJump      = 2'd2;
    localparam logic [pcSrcWidth-1:0] pcFromException = 2'd3; // handler address from mdr

    // register file write port
    localparam logic [dstWidth-1:0] dstRt = 2'd0;
    localparam logic [dstWidth-1:0] dstRd = 2'd1;
    localparam logic [dstWidth-1:0] dstRa = 2'd2;
    localparam logic [dstWidth-1:0] dstSp = 2'd3;

    localparam logic [dataSrcWidth-1:0] dataAluOut = 2'd0;
    localparam logic [dataSrcWidth-1:0] dataMem    = 2'd1;
    localparam logic [dataSrcWidth-1:0] dataPc     = 2'd2;
    localparam logic [dataSrcWidth-1:0] dataSpInit = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer import mipsIsaPkg::*, controlPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [classWidth-1:0] instrClass,
    input  wire logic                  overflow,
    output logic      [stateWidth-1:0] state,
    output logic                       excOverflow, // exception came from the alu
    output logic                       branchNe,
    output logic                       aluImm
);

    logic [stateWidth-1:0] nextState;
    logic                  ovfTrap;

    // addiu wraps silently
    assign ovfTrap = overflow && (instrClass != clsAddiu);

    always_comb begin
        case (state)
            stStackInit:   nextState = stFetchAddr;
            stFetchAddr:   nextState = stFetchWait;
            stFetchWait:   nextState = stFetchLoad;
            stFetchLoad:   nextState = stDecode;
            stDecode: begin
                case (instrClass)
                    clsAdd, clsAddi, clsAddiu: nextState = stAluExec;
                    clsLoad, clsStore:         nextState = stMemAddr;
                    clsBeq, clsBne:            nextState = stBranch;
                    clsJump:                   nextState = stJump;
                    clsJal:                    nextState = stJalLink;
                    default:                   nextState = stExcSave;
                endcase
            end
            stAluExec: begin
                if (ovfTrap) begin
                    nextState = stExcSave;
                end else if (instrClass == clsAdd) begin
                    nextState = stAluWrite;
                end else begin
                    nextState = stAluWriteImm;
                end
            end
            stMemAddr: begin
                if (instrClass == clsStore) begin
                    nextState = stStoreWrite;
                end else begin
                    nextState = stLoadRead;
                end
            end
            stLoadRead:    nextState = stLoadWait;
            stLoadWait:    nextState = stLoadCapture;
            stLoadCapture: nextState = stLoadWrite;
            stJalLink:     nextState = stJump;
            stExcSave:     nextState = stExcWait;
            stExcWait:     nextState = stExcLoad;
            stExcLoad:     nextState = stExcJump;
            stAluWrite, stAluWriteImm, stLoadWrite, stStoreWrite,
            stBranch, stJump, stExcJump: begin
                nextState = stFetchAddr;
            end
            default:       nextState = stStackInit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stStackInit;
            excOverflow <= 1'b0;
            branchNe    <= 1'b0;
            aluImm      <= 1'b0;
        end else begin
            state <= nextState;
            // per-instruction flags held through execute
            if (state == stDecode) begin
                branchNe <= (instrClass == clsBne);
                aluImm   <= (instrClass == clsAddi) || (instrClass == clsAddiu);
            end
            if (nextState == stExcSave) begin
                excOverflow <= (state == stAluExec);
            end
        end
    end

    stateDefined: assert property (@(posedge clk) disable iff (rst) state <= stExcJump);

endmodule

`default_nettype wire

// ==== verilog/datapathControlDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathControlDecode import controlPkg::*; (
    input  wire logic                    clk,
    input  wire logic [stateWidth-1:0]   state,
    input  wire logic                    excOverflow,
    input  wire logic                    branchNe,
    input  wire logic                    aluImm,
    output logic                         pcWrite,
    output logic                         pcWriteCond,
    output logic                         branchOnNotEqual,
    output logic                         memWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         operandLoad,
    output logic                         aluSrcA,
    output logic                         aluOutWrite,
    output logic                         epcWrite,
    output logic                         mdrLoad,
    output logic      [addrSrcWidth-1:0] addrSrc,
    output logic      [srcBWidth-1:0]    aluSrcB,
    output logic      [aluOpWidth-1:0]   aluOp,
    output logic      [pcSrcWidth-1:0]   pcSrc,
    output logic      [dstWidth-1:0]     regDst,
    output logic      [dataSrcWidth-1:0] regDataSrc
);

    logic [addrSrcWidth-1:0] excVector;

    assign excVector = excOverflow ? addrVecOverflow : addrVecInvalid;

    always_comb begin
        pcWrite          = 1'b0;
        pcWriteCond      = 1'b0;
        branchOnNotEqual = 1'b0;
        memWrite         = 1'b0;
        irWrite          = 1'b0;
        regWrite         = 1'b0;
        operandLoad      = 1'b0;
        aluSrcA          = 1'b0; // pc
        aluOutWrite      = 1'b0;
        epcWrite         = 1'b0;
        mdrLoad          = 1'b0;
        addrSrc          = addrPc;
        aluSrcB          = srcBReg;
        aluOp            = '0;
        pcSrc            = pcFromAlu;
        regDst           = dstRt;
        regDataSrc       = dataAluOut;

        case (state)
            stStackInit: begin
                regWrite   = 1'b1;
                regDst     = dstSp;
                regDataSrc = dataSpInit;
            end
            stFetchAddr: begin
                pcWrite = 1'b1; // pc + 4
                aluSrcB = srcBFour;
                aluOp   = aluAdd;
            end
            stFetchLoad: irWrite = 1'b1;
            stDecode: begin
                operandLoad = 1'b1;
                aluOutWrite = 1'b1; // branch target, used only by stBranch
                aluSrcB     = srcBBranchOff;
                aluOp       = aluAdd;
            end
            stAluExec: begin
                aluSrcA     = 1'b1;
                aluSrcB     = aluImm ? srcBImm : srcBReg;
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stAluWrite: begin
                regWrite = 1'b1;
                regDst   = dstRd;
            end
            stAluWriteImm: regWrite = 1'b1;
            stMemAddr: begin
                aluSrcA     = 1'b1;
                aluSrcB     = srcBImm;
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stLoadRead, stLoadWait: addrSrc = addrAluOut;
            stLoadCapture: begin
                addrSrc = addrAluOut;
                mdrLoad = 1'b1;
            end
            stLoadWrite: begin
                regWrite   = 1'b1;
                regDataSrc = dataMem;
            end
            stStoreWrite: begin
                memWrite = 1'b1;
                addrSrc  = addrAluOut;
            end
            stBranch: begin
                aluSrcA          = 1'b1;
                aluOp            = aluSub; // zero flag compares rs and rt
                pcSrc            = pcFromAluOut;
                pcWriteCond      = 1'b1;
                branchOnNotEqual = branchNe;
            end
            stJalLink: begin
                regWrite   = 1'b1;
                regDst     = dstRa;
                regDataSrc = dataPc;
            end
            stJump: begin
                pcWrite = 1'b1;
                pcSrc   = pcFromJump;
            end
            stExcSave: begin
                epcWrite = 1'b1; // epc gets pc - 4
                aluSrcB  = srcBFour;
                aluOp    = aluSub;
                addrSrc  = excVector;
            end
            stExcWait: addrSrc = excVector;
            stExcLoad: begin
                addrSrc = excVector;
                mdrLoad = 1'b1;
            end
            stExcJump: begin
                pcWrite = 1'b1;
                pcSrc   = pcFromException;
            end
            default: begin
            end
        endcase
    end

    pcWriteExclusive: assert property (@(posedge clk) !(pcWrite && pcWriteCond));

    memIrExclusive: assert property (@(posedge clk) !(memWrite && irWrite));

    // a store never also writes the register file
    memRegExclusive: assert property (@(posedge clk) !(regWrite && memWrite));

endmodule

`default_nettype wire

// ==== verilog/instrClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrClassifier import mipsIsaPkg::*; (
    input  wire logic [fieldWidth-1:0] opcode,
    input  wire logic [fieldWidth-1:0] funct,
    output logic      [classWidth-1:0] instrClass
);

    logic [classWidth-1:0] specialClass;

    // only add is supported among the R-type functs
    always_comb begin
        if (funct == functAdd) begin
            specialClass = clsAdd;
        end else begin
            specialClass = clsInvalid;
        end
    end

    always_comb begin
        case (opcode)
            opSpecial: begin
                instrClass = specialClass;
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opAddiu: begin
                instrClass = clsAddiu;
            end
            opLw: begin
                instrClass = clsLoad;
            end
            opSw: begin
                instrClass = clsStore;
            end
            opBeq: begin
                instrClass = clsBeq;
            end
            opBne: begin
                instrClass = clsBne;
            end
            opJ: begin
                instrClass = clsJump;
            end
            opJal: begin
                instrClass = clsJal;
            end
            default: begin
                instrClass = clsInvalid; // raises the invalid opcode exception
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mipsControlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsControlUnit import mipsIsaPkg::*, controlPkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [fieldWidth-1:0]   opcode,
    input  wire logic [fieldWidth-1:0]   funct,
    input  wire logic                    overflow,
    output logic                         pcWrite,
    output logic                         pcWriteCond,
    output logic                         branchOnNotEqual,
    output logic                         memWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         operandLoad,
    output logic                         aluSrcA,
    output logic                         aluOutWrite,
    output logic                         epcWrite,
    output logic                         mdrLoad,
    output logic      [addrSrcWidth-1:0] addrSrc,
    output logic      [srcBWidth-1:0]    aluSrcB,
    output logic      [aluOpWidth-1:0]   aluOp,
    output logic      [pcSrcWidth-1:0]   pcSrc,
    output logic      [dstWidth-1:0]     regDst,
    output logic      [dataSrcWidth-1:0] regDataSrc
);

    logic [classWidth-1:0] instrClass;
    logic [stateWidth-1:0] state;
    logic                  excOverflow;
    logic                  branchNe;
    logic                  aluImm;

    instrClassifier classifier0 (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer sequencer0 (
        .clk         (clk),
        .rst         (rst),
        .instrClass  (instrClass),
        .overflow    (overflow),
        .state       (state),
        .excOverflow (excOverflow),
        .branchNe    (branchNe),
        .aluImm      (aluImm)
    );

    datapathControlDecode decode0 (
        .clk              (clk),
        .state            (state),
        .excOverflow      (excOverflow),
        .branchNe         (branchNe),
        .aluImm           (aluImm),
        .pcWrite          (pcWrite),
        .pcWriteCond      (pcWriteCond),
        .branchOnNotEqual (branchOnNotEqual),
        .memWrite         (memWrite),
        .irWrite          (irWrite),
        .regWrite         (regWrite),
        .operandLoad      (operandLoad),
        .aluSrcA          (aluSrcA),
        .aluOutWrite      (aluOutWrite),
        .epcWrite         (epcWrite),
        .mdrLoad          (mdrLoad),
        .addrSrc          (addrSrc),
        .aluSrcB          (aluSrcB),
        .aluOp            (aluOp),
        .pcSrc            (pcSrc),
        .regDst           (regDst),
        .regDataSrc       (regDataSrc)
    );

endmodule

`default_nettype wire

// ==== verilog/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    localparam int fieldWidth = 6;
    localparam int classWidth = 4;

    // opcode field, bits 31:26 of the instruction
    localparam logic [fieldWidth-1:0] opSpecial = 6'h00; // R-type, funct decides
    localparam logic [fieldWidth-1:0] opJ       = 6'h02;
    localparam logic [fieldWidth-1:0] opJal     = 6'h03;
    localparam logic [fieldWidth-1:0] opBeq     = 6'h04;
    localparam logic [fieldWidth-1:0] opBne     = 6'h05;
    localparam logic [fieldWidth-1:0] opAddi    = 6'h08;
    localparam logic [fieldWidth-1:0] opAddiu   = 6'h09;
    localparam logic [fieldWidth-1:0] opLw      = 6'h23;
    localparam logic [fieldWidth-1:0] opSw      = 6'h2b;

    // funct field, bits 5:0
    localparam logic [fieldWidth-1:0] functAdd  = 6'h20;

    // instruction classes seen by the sequencer
    localparam logic [classWidth-1:0] clsAdd     = 4'd0;
    localparam logic [classWidth-1:0] clsAddi    = 4'd1;
    localparam logic [classWidth-1:0] clsAddiu   = 4'd2;
    localparam logic [classWidth-1:0] clsLoad    = 4'd3;
    localparam logic [classWidth-1:0] clsStore   = 4'd4;
    localparam logic [classWidth-1:0] clsBeq     = 4'd5;
    localparam logic [classWidth-1:0] clsBne     = 4'd6;
    localparam logic [classWidth-1:0] clsJump    = 4'd7;
    localparam logic [classWidth-1:0] clsJal     = 4'd8;
    localparam logic [classWidth-1:0] clsInvalid = 4'd15; // anything unsupported

endpackage

`default_nettype wire
